// File: hw/lsuPkg.sv
/* Load/store unit shared definitions
   Widths, TileLink-style opcodes and the command, bus and response structs */
package lsuPkg;

        localparam int ADDR_WIDTH = 32;
        localparam int DATA_WIDTH = 32;

        typedef logic [ADDR_WIDTH-1:0]   addr_t;
        typedef logic [DATA_WIDTH-1:0]   data_t;
        typedef logic [DATA_WIDTH/8-1:0] mask_t;
        // log2 of the access size in bytes
        typedef logic [1:0]              lgSize_t;

        typedef enum logic [1:0] {
                MEM_BYTE = 2'd0,
                MEM_HALF = 2'd1,
                MEM_WORD = 2'd2
        } memWidth_e;

        // A channel opcodes in TileLink encoding
        typedef enum logic [2:0] {
                TL_PUT_FULL    = 3'd0,
                TL_PUT_PARTIAL = 3'd1,
                TL_GET         = 3'd4
        } tlAOp_e;

        typedef enum logic [2:0] {
                TL_ACCESS_ACK      = 3'd0,
                TL_ACCESS_ACK_DATA = 3'd1
        } tlDOp_e;

        // Echoed through the slave so the load can be aligned on return
        typedef struct packed {
                logic [1:0] offset;
                memWidth_e  width;
                logic       isSigned;
        } loadTag_t;

        typedef struct packed {
                logic      isStore;
                memWidth_e width;
                logic      isSigned;
                addr_t     addr;
                data_t     data;
        } memCmd_t;

        typedef struct packed {
                tlAOp_e   opcode;
                lgSize_t  size;
                mask_t    mask;
                addr_t    address;
                data_t    data;
                loadTag_t source;
        } tlA_t;

        typedef struct packed {
                tlDOp_e   opcode;
                logic     denied;
                data_t    data;
                loadTag_t source;
        } tlD_t;

        typedef struct packed {
                logic  error;
                data_t data;
        } memRsp_t;

endpackage

// File: hw/lsuRequest.sv
/* Request former
   Turns core load/store commands into registered A-channel beats */
`timescale 1ns/10ps

module lsuRequest import lsuPkg::*; (
        input  logic    i_clk,
        input  logic    i_reset,
        // Core command
        input  logic    i_cmdValid,
        output logic    o_cmdReady,
        input  memCmd_t i_cmd,
        // A channel out
        output logic    o_aValid,
        input  logic    i_aReady,
        output tlA_t    o_a
);

        tlA_t nextBeat;

        // Stage can take a command when empty or when its beat leaves now
        assign o_cmdReady = !o_aValid || i_aReady;

        //========================================
        // Beat formation
        //========================================
        always_comb begin
                nextBeat.size           = lgSize_t'(i_cmd.width);
                nextBeat.address        = i_cmd.addr;
                nextBeat.source.offset  = i_cmd.addr[1:0];
                nextBeat.source.width   = i_cmd.width;
                nextBeat.source.isSigned = i_cmd.isSigned;

                // Lane mask and store data replicated over all lanes
                case (i_cmd.width)
                        MEM_BYTE: begin
                                nextBeat.mask = mask_t'(4'b0001) << i_cmd.addr[1:0];
                                nextBeat.data = {4{i_cmd.data[7:0]}};
                        end
                        MEM_HALF: begin
                                nextBeat.mask = mask_t'(4'b0011) << i_cmd.addr[1:0];
                                nextBeat.data = {2{i_cmd.data[15:0]}};
                        end
                        default: begin
                                nextBeat.mask = '1;
                                nextBeat.data = i_cmd.data;
                        end
                endcase

                if (!i_cmd.isStore) begin
                        nextBeat.opcode = TL_GET;
                        nextBeat.mask   = '1;
                end else if (i_cmd.width == MEM_WORD) begin
                        nextBeat.opcode = TL_PUT_FULL;
                end else begin
                        nextBeat.opcode = TL_PUT_PARTIAL;
                end
        end

        //========================================
        // Output register
        //========================================
        always_ff @(posedge i_clk) begin
                if (i_reset) begin
                        o_aValid <= 1'b0;
                end else if (o_cmdReady) begin
                        o_aValid <= i_cmdValid;
                end
        end

        // Payload only loads on an accepted command
        always_ff @(posedge i_clk) begin
                if (i_cmdValid && o_cmdReady) begin
                        o_a <= nextBeat;
                end
        end

endmodule

// File: hw/reqQueue.sv
/* Request queue
   Circular FIFO holding A-channel beats between former and slave */
`timescale 1ns/10ps

module reqQueue import lsuPkg::*; #(
        parameter int QUEUE_DEPTH = 4
) (
        input  logic i_clk,
        input  logic i_reset,
        // Write side
        input  logic i_inValid,
        output logic o_inReady,
        input  tlA_t i_in,
        // Read side
        output logic o_outValid,
        input  logic i_outReady,
        output tlA_t o_out
);

        localparam int PTR_W = $clog2(QUEUE_DEPTH);
        localparam logic [PTR_W:0] FULL_COUNT = QUEUE_DEPTH[PTR_W:0];

        tlA_t             entries [QUEUE_DEPTH];
        logic [PTR_W-1:0] wrPtr;
        logic [PTR_W-1:0] rdPtr;
        logic [PTR_W:0]   count;
        logic             doWrite;
        logic             doRead;

        assign o_outValid = (count != '0);
        // When full a write is still taken if the head leaves this cycle
        assign o_inReady  = (count != FULL_COUNT) || i_outReady;
        assign o_out      = entries[rdPtr];

        assign doWrite = i_inValid && o_inReady;
        assign doRead  = o_outValid && i_outReady;

        always_ff @(posedge i_clk) begin
                if (i_reset) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                end else begin
                        if (doWrite) begin
                                wrPtr <= wrPtr + 1'b1;
                        end
                        if (doRead) begin
                                rdPtr <= rdPtr + 1'b1;
                        end
                        // Pointers wrap by themselves since depth is a power of two
                        case ({doWrite, doRead})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        always_ff @(posedge i_clk) begin
                if (doWrite) begin
                        entries[wrPtr] <= i_in;
                end
        end

endmodule

// File: hw/sramSlave.sv
/* SRAM slave
   Word-wide memory executing Get/Put beats, one D-channel response held */
`timescale 1ns/10ps

module sramSlave import lsuPkg::*; #(
        parameter int MEM_WORDS = 256
) (
        input  logic i_clk,
        input  logic i_reset,
        // A channel in
        input  logic i_aValid,
        output logic o_aReady,
        input  tlA_t i_a,
        // D channel out
        output logic o_dValid,
        input  logic i_dReady,
        output tlD_t o_d
);

        localparam int IDX_W = $clog2(MEM_WORDS);

        data_t             mem [MEM_WORDS];
        logic [IDX_W-1:0]  wordIdx;
        logic              accept;
        logic              isGet;
        logic              misaligned;

        assign o_aReady = !o_dValid || i_dReady;
        assign accept   = i_aValid && o_aReady;
        assign isGet    = (i_a.opcode == TL_GET);

        // Upper address bits are ignored so the array wraps
        assign wordIdx  = i_a.address[IDX_W+1:2];

        //========================================
        // Alignment check
        //========================================
        always_comb begin
                case (i_a.size)
                        2'd0:    misaligned = 1'b0;
                        2'd1:    misaligned = i_a.address[0];
                        default: misaligned = (i_a.address[1:0] != 2'b00);
                endcase
        end

        //========================================
        // Array write
        //========================================
        always_ff @(posedge i_clk) begin
                if (accept && !isGet && !misaligned) begin
                        for (int lane = 0; lane < DATA_WIDTH/8; lane++) begin
                                if (i_a.mask[lane]) begin
                                        mem[wordIdx][lane*8 +: 8] <= i_a.data[lane*8 +: 8];
                                end
                        end
                end
        end

        //========================================
        // D response register
        //========================================
        always_ff @(posedge i_clk) begin
                if (i_reset) begin
                        o_dValid <= 1'b0;
                end else if (o_aReady) begin
                        o_dValid <= i_aValid;
                end
        end

        always_ff @(posedge i_clk) begin
                if (accept) begin
                        o_d.opcode <= isGet ? TL_ACCESS_ACK_DATA : TL_ACCESS_ACK;
                        o_d.denied <= misaligned;
                        o_d.source <= i_a.source;
                        // Read data only for an aligned Get and zero otherwise
                        if (isGet && !misaligned) begin
                                o_d.data <= mem[wordIdx];
                        end else begin
                                o_d.data <= '0;
                        end
                end
        end

endmodule

// File: hw/loadResponse.sv
/* Load response stage
   Registers D beats, extracts and sign-extends load data for the core */
`timescale 1ns/10ps

module loadResponse import lsuPkg::*; (
        input  logic    i_clk,
        input  logic    i_reset,
        // D channel in
        input  logic    i_dValid,
        output logic    o_dReady,
        input  tlD_t    i_d,
        // Core response
        output logic    o_rspValid,
        input  logic    i_rspReady,
        output memRsp_t o_rsp
);

        data_t   shifted;
        memRsp_t nextRsp;

        assign o_dReady = !o_rspValid || i_rspReady;

        // Bring the addressed lane down to bit 0
        assign shifted = i_d.data >> {i_d.source.offset, 3'b000};

        always_comb begin
                nextRsp.error = i_d.denied;
                nextRsp.data  = '0;
                if (!i_d.denied && i_d.opcode == TL_ACCESS_ACK_DATA) begin
                        case (i_d.source.width)
                                MEM_BYTE: nextRsp.data = i_d.source.isSigned
                                        ? {{(DATA_WIDTH-8){shifted[7]}}, shifted[7:0]}
                                        : {{(DATA_WIDTH-8){1'b0}}, shifted[7:0]};
                                MEM_HALF: nextRsp.data = i_d.source.isSigned
                                        ? {{(DATA_WIDTH-16){shifted[15]}}, shifted[15:0]}
                                        : {{(DATA_WIDTH-16){1'b0}}, shifted[15:0]};
                                default:  nextRsp.data = i_d.data;
                        endcase
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_reset) begin
                        o_rspValid <= 1'b0;
                end else if (o_dReady) begin
                        o_rspValid <= i_dValid;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_dValid && o_dReady) begin
                        o_rsp <= nextRsp;
                end
        end

endmodule

// File: hw/lsuTop.sv
/* Data-memory path top level
   Request former, request queue, SRAM slave and load response in a chain */
`timescale 1ns/10ps

module lsuTop import lsuPkg::*; #(
        parameter int QUEUE_DEPTH = 4,
        parameter int MEM_WORDS   = 256
) (
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_cmdValid,
        output logic    o_cmdReady,
        input  memCmd_t i_cmd,
        output logic    o_rspValid,
        input  logic    i_rspReady,
        output memRsp_t o_rsp
);

        // Former to queue
        logic reqAValid;
        logic reqAReady;
        tlA_t reqA;
        // Queue to slave
        logic memAValid;
        logic memAReady;
        tlA_t memA;
        // Slave to response stage
        logic dValid;
        logic dReady;
        tlD_t dBeat;

        lsuRequest request_i (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_cmdValid (i_cmdValid),
                .o_cmdReady (o_cmdReady),
                .i_cmd      (i_cmd),
                .o_aValid   (reqAValid),
                .i_aReady   (reqAReady),
                .o_a        (reqA)
        );

        reqQueue #(
                .QUEUE_DEPTH(QUEUE_DEPTH)
        ) queue_i (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_inValid  (reqAValid),
                .o_inReady  (reqAReady),
                .i_in       (reqA),
                .o_outValid (memAValid),
                .i_outReady (memAReady),
                .o_out      (memA)
        );

        sramSlave #(
                .MEM_WORDS(MEM_WORDS)
        ) slave_i (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_aValid (memAValid),
                .o_aReady (memAReady),
                .i_a      (memA),
                .o_dValid (dValid),
                .i_dReady (dReady),
                .o_d      (dBeat)
        );

        loadResponse response_i (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_dValid   (dValid),
                .o_dReady   (dReady),
                .i_d        (dBeat),
                .o_rspValid (o_rspValid),
                .i_rspReady (i_rspReady),
                .o_rsp      (o_rsp)
        );

endmodule

// File: verif/tlBus_asserts.sv
/* TileLink handshake checks
   Bound into the LSU top level, watches the internal A and D channels */
`timescale 1ns/10ps

module tlBus_asserts import lsuPkg::*; (
        input logic i_clk,
        input logic i_reset,
        input logic i_reqAValid,
        input logic i_reqAReady,
        input tlA_t i_reqA,
        input logic i_memAValid,
        input logic i_memAReady,
        input tlA_t i_memA,
        input logic i_dValid,
        input logic i_dReady,
        input tlD_t i_dBeat,
        input logic i_rspValid
);

        // Stalled beats hold their payload until taken
        reqAStable: assert property (@(posedge i_clk) disable iff (i_reset)
                i_reqAValid && !i_reqAReady |=> i_reqAValid && $stable(i_reqA))
                else $error("former A beat changed or dropped while stalled");

        memAStable: assert property (@(posedge i_clk) disable iff (i_reset)
                i_memAValid && !i_memAReady |=> i_memAValid && $stable(i_memA))
                else $error("queue A beat changed or dropped while stalled");

        dStable: assert property (@(posedge i_clk) disable iff (i_reset)
                i_dValid && !i_dReady |=> i_dValid && $stable(i_dBeat))
                else $error("D beat changed or dropped while stalled");

        // Nothing valid in the cycle after reset
        resetQuiet: assert property (@(posedge i_clk)
                i_reset |=> !i_reqAValid && !i_memAValid && !i_dValid && !i_rspValid)
                else $error("valid high in the cycle after reset");

endmodule

bind lsuTop tlBus_asserts asserts_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_reqAValid (reqAValid),
        .i_reqAReady (reqAReady),
        .i_reqA      (reqA),
        .i_memAValid (memAValid),
        .i_memAReady (memAReady),
        .i_memA      (memA),
        .i_dValid    (dValid),
        .i_dReady    (dReady),
        .i_dBeat     (dBeat),
        .i_rspValid  (o_rspValid)
);

// File: verif/lsuTb.sv
/* Load/store unit testbench
   Drives load/store commands and checks responses against a shadow memory */
`timescale 1ns/10ps

module lsuTb import lsuPkg::*; ();

        localparam int QUEUE_DEPTH    = 4;
        localparam int MEM_WORDS      = 256;
        localparam int INIT_WORDS     = 16;
        localparam int RANDOM_CMDS    = 60;
        // Commands issued by tests 2 to 6
        localparam int NUM_CMDS       = 32 + 16 + 28 + 16 + RANDOM_CMDS;
        localparam int TIMEOUT_CYCLES = 20 * NUM_CMDS + 100;

        logic    clk;
        logic    reset;
        logic    cmdValid;
        logic    cmdReady;
        memCmd_t cmd;
        logic    rspValid;
        logic    rspReady;
        memRsp_t rsp;

        // Byte image of the 16 words under test
        logic [7:0]  shadow [4*INIT_WORDS];
        memRsp_t     expQ [$];
        memRsp_t     expected;
        int          errCount   = 0;
        int          cmdCount   = 0;
        int          rspCount   = 0;
        int          cycleCount = 0;
        logic [31:0] rngState   = 32'd6;
        // Stall pattern uses its own stream from the inverted seed
        logic [31:0] stallState = ~32'd6;
        logic        stallOn    = 1'b0;

        lsuTop #(
                .QUEUE_DEPTH(QUEUE_DEPTH),
                .MEM_WORDS  (MEM_WORDS)
        ) dut_i (
                .i_clk      (clk),
                .i_reset    (reset),
                .i_cmdValid (cmdValid),
                .o_cmdReady (cmdReady),
                .i_cmd      (cmd),
                .o_rspValid (rspValid),
                .i_rspReady (rspReady),
                .o_rsp      (rsp)
        );

        always #5 clk = ~clk;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic logic [31:0] nextRand();
                rngState = xorshift32(rngState);
                return rngState;
        endfunction

        function automatic memCmd_t makeCmd(input logic isStore, input memWidth_e width,
                        input logic isSigned, input addr_t addr, input data_t data);
                memCmd_t c;
                c.isStore  = isStore;
                c.width    = width;
                c.isSigned = isSigned;
                c.addr     = addr;
                c.data     = data;
                return c;
        endfunction

        //========================================
        // Reference model
        //========================================
        function automatic memRsp_t refModel(input memCmd_t c);
                int      nBytes;
                int      base;
                data_t   value;
                memRsp_t r;
                nBytes  = 1 << c.width;
                base    = int'(c.addr[5:0]);
                r.error = 1'b0;
                r.data  = '0;
                value   = '0;
                if (base % nBytes != 0) begin
                        // Misaligned access leaves memory untouched
                        r.error = 1'b1;
                end else if (c.isStore) begin
                        for (int i = 0; i < nBytes; i++) begin
                                shadow[base + i] = c.data[8*i +: 8];
                        end
                end else begin
                        for (int i = 0; i < nBytes; i++) begin
                                value[8*i +: 8] = shadow[base + i];
                        end
                        if (c.isSigned && nBytes < 4 && value[8*nBytes - 1]) begin
                                for (int i = 8*nBytes; i < DATA_WIDTH; i++) begin
                                        value[i] = 1'b1;
                                end
                        end
                        r.data = value;
                end
                return r;
        endfunction

        task automatic issue(input memCmd_t c);
                cmdValid <= 1'b1;
                cmd      <= c;
                @(negedge clk);
                while (!cmdReady) begin
                        @(negedge clk);
                end
                @(posedge clk);
                cmdValid <= 1'b0;
        endtask

        task automatic drain();
                while (expQ.size() != 0) begin
                        @(posedge clk);
                end
                @(posedge clk);
        endtask

        task automatic reportTest(input string name, input int errsAtStart);
                $display("test %s done, %0d errors", name, errCount - errsAtStart);
        endtask

        //========================================
        // Compare and command monitor
        //========================================
        always @(negedge clk) begin
                if (!reset && rspValid && rspReady) begin
                        rspCount++;
                        assert (expQ.size() != 0) else begin
                                $display("response at %0t arrived with no command outstanding",
                                        $time);
                                errCount++;
                        end
                        if (expQ.size() != 0) begin
                                expected = expQ.pop_front();
                                assert (rsp.error === expected.error) else begin
                                        $display("mismatch at %0t: o_rsp.error expected %b got %b",
                                                $time, expected.error, rsp.error);
                                        errCount++;
                                end
                                assert (rsp.data === expected.data) else begin
                                        $display("mismatch at %0t: o_rsp.data expected %h got %h",
                                                $time, expected.data, rsp.data);
                                        errCount++;
                                end
                        end
                end
                // Accepted at the next rising edge and applied in command order
                if (!reset && cmdValid && cmdReady) begin
                        expQ.push_back(refModel(cmd));
                        cmdCount++;
                end
        end

        // Random back-pressure on the response port
        always @(posedge clk) begin
                if (stallOn) begin
                        stallState = xorshift32(stallState);
                        rspReady <= (stallState[2:0] > 3'd2);
                end else begin
                        rspReady <= 1'b1;
                end
        end

        always @(posedge clk) begin
                cycleCount++;
                if (cycleCount >= TIMEOUT_CYCLES) begin
                        $display("timeout after %0d cycles with %0d responses outstanding",
                                cycleCount, expQ.size());
                        $display("TEST FAILED");
                        $finish;
                end
        end

        initial begin
                int          testErrs;
                logic [31:0] r;
                addr_t       addr;
                clk      = 1'b0;
                reset    = 1'b1;
                cmdValid = 1'b0;
                cmd      = '0;
                rspReady = 1'b1;
                repeat (2) @(posedge clk);
                reset <= 1'b0;

                // Test 1 idles and expects no response
                testErrs = errCount;
                repeat (4) begin
                        @(negedge clk);
                        assert (!rspValid) else begin
                                $display("mismatch at %0t: o_rspValid expected 0 got %b",
                                        $time, rspValid);
                                errCount++;
                        end
                end
                @(posedge clk);
                reportTest("reset idle", testErrs);

                // Test 2 fills all words and then runs word store/load pairs
                testErrs = errCount;
                for (int w = 0; w < INIT_WORDS; w++) begin
                        issue(makeCmd(1'b1, MEM_WORD, 1'b0, addr_t'(4 * w), nextRand()));
                end
                repeat (8) begin
                        r    = nextRand();
                        addr = addr_t'({r[3:0], 2'b00});
                        issue(makeCmd(1'b1, MEM_WORD, 1'b0, addr, nextRand()));
                        issue(makeCmd(1'b0, MEM_WORD, 1'b0, addr, '0));
                end
                drain();
                reportTest("word store/load", testErrs);

                // Test 3 puts a byte and a half in opposite halves and loads the word
                testErrs = errCount;
                for (int i = 0; i < 4; i++) begin
                        r    = nextRand();
                        addr = addr_t'({r[3:0], 2'b00});
                        issue(makeCmd(1'b1, MEM_WORD, 1'b0, addr, nextRand()));
                        if (r[4]) begin
                                issue(makeCmd(1'b1, MEM_HALF, 1'b0, addr + 2, nextRand()));
                                issue(makeCmd(1'b1, MEM_BYTE, 1'b0, addr + addr_t'(r[5]),
                                        nextRand()));
                        end else begin
                                issue(makeCmd(1'b1, MEM_HALF, 1'b0, addr, nextRand()));
                                issue(makeCmd(1'b1, MEM_BYTE, 1'b0, addr + 2 + addr_t'(r[5]),
                                        nextRand()));
                        end
                        issue(makeCmd(1'b0, MEM_WORD, 1'b0, addr, '0));
                end
                drain();
                reportTest("lane merge", testErrs);

                // Test 4 writes all negative lanes on odd passes and positive ones on even
                testErrs = errCount;
                for (int i = 0; i < 4; i++) begin
                        r    = nextRand();
                        addr = addr_t'({r[3:0], 2'b00});
                        issue(makeCmd(1'b1, MEM_WORD, 1'b0, addr, (i % 2 == 1)
                                ? (nextRand() | 32'h8080_8080) : (nextRand() & 32'h7f7f_7f7f)));
                        for (int b = 0; b < 4; b++) begin
                                issue(makeCmd(1'b0, MEM_BYTE, r[4 + b], addr + b, '0));
                        end
                        for (int h = 0; h < 2; h++) begin
                                issue(makeCmd(1'b0, MEM_HALF, r[8 + h], addr + 2 * h, '0));
                        end
                end
                drain();
                reportTest("sign extension", testErrs);

                // Test 5 tries misaligned accesses and reads the word back aligned
                testErrs = errCount;
                for (int i = 0; i < 4; i++) begin
                        r    = nextRand();
                        addr = addr_t'({r[3:0], 2'b00});
                        issue(makeCmd(1'b1, MEM_HALF, 1'b0, addr + (r[4] ? 3 : 1), nextRand()));
                        issue(makeCmd(1'b1, MEM_WORD, 1'b0, addr + 1 + (r[6:5] % 3), nextRand()));
                        issue(makeCmd(1'b0, MEM_HALF, 1'b1, addr + 1, '0));
                        issue(makeCmd(1'b0, MEM_WORD, 1'b0, addr, '0));
                end
                drain();
                reportTest("misaligned access", testErrs);

                // Test 6 runs random traffic under response back-pressure
                testErrs = errCount;
                stallOn <= 1'b1;
                for (int i = 0; i < RANDOM_CMDS; i++) begin
                        r = nextRand();
                        if (r[15:13] == 3'd0) begin
                                @(posedge clk);
                        end
                        issue(makeCmd(r[0], memWidth_e'(r[2:1] % 3), r[3], addr_t'(r[9:4]),
                                nextRand()));
                end
                drain();
                stallOn <= 1'b0;
                assert (rspCount == cmdCount) else begin
                        $display("got %0d responses for %0d commands", rspCount, cmdCount);
                        errCount++;
                end
                reportTest("random with stalls", testErrs);

                $display("commands %0d, responses %0d, errors %0d",
                        cmdCount, rspCount, errCount);
                if (errCount == 0) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

// File: all.f
hw/lsuPkg.sv
hw/lsuRequest.sv
hw/reqQueue.sv
hw/sramSlave.sv
hw/loadResponse.sv
hw/lsuTop.sv
verif/tlBus_asserts.sv
verif/lsuTb.sv

// File: Makefile
# Verilator simulation of the load/store unit

VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
